// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // basic widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;

  // alu funct3 values
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // branch funct3 values
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  // funct7 selects SUB and MUL inside the op class
  localparam logic [6:0] f7_sub = 7'b0100000;
  localparam logic [6:0] f7_mul = 7'b0000001;
  localparam logic [2:0] f3_mul = 3'b000;

  // fetch to execute register, 65 bits
  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_t inst;
  } fetch_exec_t;

  // execute to memory register, 100 bits
  typedef struct packed {
    logic  valid;
    inst_t inst;
    word_t result;
    word_t store_data;
    logic  reg_wr;
    logic  mem_read;
    logic  mem_write;
  } exec_mem_t;

  // load stall machine
  typedef enum logic {
    normal,
    stalled
  } hazard_state_e;

endpackage

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire                clk,
  input  wire                reset,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  output core_pkg::word_t    rd1,
  output core_pkg::word_t    rd2,
  input  wire                wr_en,
  input  core_pkg::reg_idx_t wr_idx,
  input  core_pkg::word_t    wr_data
);

  import core_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != 5'd0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // x0 first, then bypass of the write in flight
  assign rd1 = (rs1 == 5'd0) ? '0 : (wr_en && wr_idx == rs1) ? wr_data : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : (wr_en && wr_idx == rs2) ? wr_data : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  wire             clk,
  input  wire             reset,
  input  wire             start,
  input  core_pkg::word_t a,
  input  core_pkg::word_t b,
  input  wire             advance,
  output core_pkg::word_t product,
  output wire             m_busy,
  output wire             m_done
);

  import core_pkg::*;

  logic       running;
  logic       done;
  logic [4:0] count;
  word_t      mcand;
  word_t      mplier;
  word_t      acc;

  // start is a level, dropping it aborts the operation
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      running <= 1'b0;
      done    <= 1'b0;
    end else if (done) begin
      if (advance) begin
        done <= 1'b0;
      end
    end else if (!running) begin
      running <= 1'b1;
    end else if (count == 5'd31) begin
      running <= 1'b0;
      done    <= 1'b1;
    end
  end

  // one partial product per cycle, low word only
  always_ff @(posedge clk) begin
    if (start && !running && !done) begin
      mcand  <= a;
      mplier <= b;
      acc    <= '0;
      count  <= '0;
    end else if (running) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      count  <= count + 5'd1;
    end
  end

  assign product = acc;
  assign m_busy  = start & ~done;
  assign m_done  = done;

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter core_pkg::word_t reset_vector = 32'h0000_0000,
  parameter core_pkg::word_t trap_vector  = 32'h0000_0200
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   stall,
  input  wire                   flush,
  input  wire                   irq,
  input  core_pkg::word_t       redirect_target,
  output core_pkg::word_t       imem_addr,
  input  core_pkg::inst_t       imem_rdata,
  output core_pkg::fetch_exec_t fe
);

  import core_pkg::*;

  word_t pc;
  word_t pc_next;
  word_t flush_target;

  // interrupt wins over a branch redirect
  assign flush_target = irq ? trap_vector : redirect_target;
  assign pc_next = pc + 32'd4;

  // instruction memory answers in the same cycle
  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
    end else if (flush) begin
      pc <= flush_target;
    end else if (!stall) begin
      pc <= pc_next;
    end
  end

  // flush drops the slot that was being fetched
  always_ff @(posedge clk) begin
    if (reset) begin
      fe <= '0;
    end else if (flush) begin
      fe <= '0;
    end else if (!stall) begin
      fe.valid <= 1'b1;
      fe.pc    <= pc;
      fe.inst  <= imem_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  wire                   clk,
  input  wire                   reset,
  input  core_pkg::fetch_exec_t fe,
  input  wire                   forward_1,
  input  wire                   forward_2,
  input  wire                   stall,
  output core_pkg::exec_mem_t   em,
  output wire                   branch_taken,
  output core_pkg::word_t       redirect_target,
  output wire                   m_busy,
  output wire                   m_done,
  input  wire                   wb_en,
  input  core_pkg::reg_idx_t    wb_idx,
  input  core_pkg::word_t       wb_data
);

  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      rd1, rd2;
  word_t      op1, op2;
  word_t      imm_i, imm_s, imm_b, imm_j;
  word_t      alu_b, alu_out, addr, result, product;
  logic       is_op, is_op_imm, is_load, is_store, is_branch, is_jal, is_mul;
  logic       is_sub, branch_cond;
  exec_mem_t  em_next;

  assign opcode = fe.inst[6:0];
  assign funct3 = fe.inst[14:12];
  assign funct7 = fe.inst[31:25];
  assign rs1    = fe.inst[19:15];
  assign rs2    = fe.inst[24:20];

  assign imm_i = {{20{fe.inst[31]}}, fe.inst[31:20]};
  assign imm_s = {{20{fe.inst[31]}}, fe.inst[31:25], fe.inst[11:7]};
  assign imm_b = {{19{fe.inst[31]}}, fe.inst[31], fe.inst[7], fe.inst[30:25],
                  fe.inst[11:8], 1'b0};
  assign imm_j = {{11{fe.inst[31]}}, fe.inst[31], fe.inst[19:12], fe.inst[20],
                  fe.inst[30:21], 1'b0};

  assign is_op     = (opcode == opc_op);
  assign is_op_imm = (opcode == opc_op_imm);
  assign is_load   = (opcode == opc_load);
  assign is_store  = (opcode == opc_store);
  assign is_branch = (opcode == opc_branch);
  assign is_jal    = (opcode == opc_jal);
  assign is_mul    = is_op && funct7 == f7_mul && funct3 == f3_mul;
  assign is_sub    = is_op && funct7 == f7_sub;

  regfile u_regfile (
    .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
    .wr_en(wb_en), .wr_idx(wb_idx), .wr_data(wb_data)
  );

  // memory stage ALU result bypass
  assign op1 = forward_1 ? em.result : rd1;
  assign op2 = forward_2 ? em.result : rd2;

  mul_unit u_mul (
    .clk(clk), .reset(reset), .start(fe.valid & is_mul), .a(op1), .b(op2),
    .advance(~stall), .product(product), .m_busy(m_busy), .m_done(m_done)
  );

  assign alu_b = is_op ? op2 : imm_i;
  assign addr  = op1 + (is_store ? imm_s : imm_i);

  always_comb begin
    case (funct3)
      f3_add_sub: alu_out = is_sub ? op1 - alu_b : op1 + alu_b;
      f3_slt:     alu_out = {31'b0, $signed(op1) < $signed(alu_b)};
      f3_xor:     alu_out = op1 ^ alu_b;
      f3_or:      alu_out = op1 | alu_b;
      f3_and:     alu_out = op1 & alu_b;
      default:    alu_out = op1 + alu_b;
    endcase
  end

  always_comb begin
    if (is_mul) begin
      result = product;
    end else if (is_jal) begin
      result = fe.pc + 32'd4;
    end else if (is_load || is_store) begin
      result = addr;
    end else begin
      result = alu_out;
    end
  end

  assign branch_cond = (funct3 == f3_bne) ? (op1 != op2) : (op1 == op2);
  // held back while stalled so a redirect never lands on a frozen slot
  assign branch_taken = fe.valid & ~stall & (is_jal | (is_branch & branch_cond));
  assign redirect_target = fe.pc + (is_jal ? imm_j : imm_b);

  always_comb begin
    em_next            = '0;
    em_next.valid      = fe.valid;
    em_next.inst       = fe.inst;
    em_next.result     = result;
    em_next.store_data = op2;
    em_next.reg_wr     = fe.valid & (is_op | is_op_imm | is_load | is_jal);
    em_next.mem_read   = fe.valid & is_load;
    em_next.mem_write  = fe.valid & is_store;
  end

  // a stall sends a bubble down to memory
  always_ff @(posedge clk) begin
    if (reset || stall) begin
      em <= '0;
    end else begin
      em <= em_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  core_pkg::exec_mem_t em,
  output core_pkg::word_t     dmem_addr,
  output core_pkg::word_t     dmem_wdata,
  output wire                 dmem_we,
  input  core_pkg::word_t     dmem_rdata,
  output wire                 wb_en,
  output core_pkg::reg_idx_t  wb_idx,
  output core_pkg::word_t     wb_data
);

  // address is the ALU result computed in execute
  assign dmem_addr  = em.result;
  assign dmem_wdata = em.store_data;

  // only a live store strobes the memory
  assign dmem_we = em.valid & em.mem_write;

  // destination register from the rd field
  assign wb_idx = em.inst[11:7];

  // x0 writes are dropped here already
  assign wb_en = em.valid & em.reg_wr & (wb_idx != 5'd0);

  // loads take the memory word, everything else the ALU result
  assign wb_data = em.mem_read ? dmem_rdata : em.result;

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  wire             clk,
  input  wire             reset,
  input  wire             reg_wr,
  input  wire             mem_read,
  input  wire             branch_taken,
  input  wire             irq,
  input  core_pkg::inst_t inst_exec,
  input  core_pkg::inst_t inst_mem,
  input  wire             m_busy,
  input  wire             m_done,
  output wire             forward_1,
  output wire             forward_2,
  output wire             flush,
  output wire             stall
);

  import core_pkg::*;

  reg_idx_t      rs1_exec, rs2_exec, rd_mem;
  hazard_state_e state, state_next;
  logic          load_stall;
  logic          mul_stall;
  logic          mem_alu_write;

  assign rs1_exec = inst_exec[19:15];
  assign rs2_exec = inst_exec[24:20];
  assign rd_mem   = inst_mem[11:7];

  // loads are never forwarded, they go through the stall instead
  assign mem_alu_write = reg_wr & ~mem_read & (rd_mem != 5'd0);
  assign forward_1 = mem_alu_write & (rs1_exec == rd_mem);
  assign forward_2 = mem_alu_write & (rs2_exec == rd_mem);

  assign flush = branch_taken | irq;

  assign mul_stall = m_busy & ~m_done;

  // one stall cycle per load in memory
  always_comb begin
    load_stall = 1'b0;
    state_next = normal;
    case (state)
      normal: begin
        if (mem_read & reg_wr) begin
          load_stall = 1'b1;
          state_next = stalled;
        end
      end
      stalled: state_next = normal;
      default: state_next = normal;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= normal;
    end else begin
      state <= state_next;
    end
  end

  assign stall = load_stall | mul_stall;

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter core_pkg::word_t reset_vector = 32'h0000_0000,
  parameter core_pkg::word_t trap_vector  = 32'h0000_0200
) (
  input  wire             clk,
  input  wire             reset,
  output core_pkg::word_t imem_addr,
  input  core_pkg::inst_t imem_rdata,
  output core_pkg::word_t dmem_addr,
  output core_pkg::word_t dmem_wdata,
  input  core_pkg::word_t dmem_rdata,
  output wire             dmem_we,
  input  wire             irq
);

  import core_pkg::*;

  fetch_exec_t fe;
  exec_mem_t   em;
  logic        stall, flush;
  logic        forward_1, forward_2;
  logic        branch_taken;
  word_t       redirect_target;
  logic        m_busy, m_done;
  logic        wb_en;
  reg_idx_t    wb_idx;
  word_t       wb_data;

  fetch_stage #(
    .reset_vector(reset_vector),
    .trap_vector (trap_vector)
  ) u_fetch (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush), .irq(irq),
    .redirect_target(redirect_target), .imem_addr(imem_addr),
    .imem_rdata(imem_rdata), .fe(fe)
  );

  exec_stage u_exec (
    .clk(clk), .reset(reset), .fe(fe), .forward_1(forward_1), .forward_2(forward_2),
    .stall(stall), .em(em), .branch_taken(branch_taken),
    .redirect_target(redirect_target), .m_busy(m_busy), .m_done(m_done),
    .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data)
  );

  mem_stage u_mem (
    .em(em), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata), .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data)
  );

  // memory stage controls count only for live entries
  hazard_unit u_hazard (
    .clk(clk), .reset(reset), .reg_wr(em.valid & em.reg_wr),
    .mem_read(em.valid & em.mem_read), .branch_taken(branch_taken), .irq(irq),
    .inst_exec(fe.inst), .inst_mem(em.inst), .m_busy(m_busy), .m_done(m_done),
    .forward_1(forward_1), .forward_2(forward_2), .flush(flush), .stall(stall)
  );

endmodule

`default_nettype wire

// ==== sim/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] addi_op(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
  return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

// loads and stores use x0 as base, so the offset is the address
function automatic logic [31:0] lw_abs(input logic [4:0] rd, input logic [11:0] addr);
  return {addr, 5'd0, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] sw_abs(input logic [4:0] rs2, input logic [11:0] addr);
  return {addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jump_op(input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
endfunction

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] random_word();
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < 32; i++) begin
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    v    = {v[30:0], fb};
  end
  return v;
endfunction

task automatic put(input logic [31:0] inst);
  imem[wr_ptr] = inst;
  wr_ptr++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
  exp_addr.push_back(addr);
  exp_data.push_back(data);
endtask

// operands at 0x100, 0x104, 0x108 end up in x1, x2 and x3
task automatic build_program(input int p);
  logic [31:0] a, b, c, s, d, x;
  a = random_word();
  b = random_word();
  c = random_word();
  dmem[64] = a;
  // branch test wants x1 == x2
  dmem[65] = (p == 2) ? a : b;
  dmem[66] = c;
  wr_ptr = 0;
  put(lw_abs(5'd1, 12'h100));
  put(lw_abs(5'd2, 12'h104));
  case (p)
    0: begin
      s = a + b;
      d = s - b;
      x = b ^ d;
      put(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
      put(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
      put(r_type(7'h00, 5'd4, 5'd2, 3'b100, 5'd5));
      put(r_type(7'h00, 5'd3, 5'd5, 3'b010, 5'd6));
      put(sw_abs(5'd6, 12'h180));
      put(sw_abs(5'd5, 12'h184));
      put(sw_abs(5'd4, 12'h188));
      expect_store(32'h180, {31'b0, $signed(x) < $signed(s)});
      expect_store(32'h184, x);
      expect_store(32'h188, d);
    end
    1: begin
      put(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
      put(sw_abs(5'd3, 12'h190));
      expect_store(32'h190, a + b);
    end
    2: begin
      put(lw_abs(5'd3, 12'h108));
      put(branch_op(3'b000, 5'd1, 5'd2, 13'd8));
      // shadow store of the taken beq
      put(sw_abs(5'd1, 12'h1a0));
      put(sw_abs(5'd2, 12'h1a4));
      put(branch_op(3'b001, 5'd1, 5'd2, 13'd8));
      put(sw_abs(5'd3, 12'h1a8));
      expect_store(32'h1a4, a);
      expect_store(32'h1a8, c);
    end
    3: begin
      put(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd3));
      put(r_type(7'h00, 5'd1, 5'd3, 3'b000, 5'd4));
      put(sw_abs(5'd3, 12'h1b0));
      put(sw_abs(5'd4, 12'h1b4));
      expect_store(32'h1b0, a * b);
      expect_store(32'h1b4, a * b + a);
    end
    4: begin
      put(sw_abs(5'd1, 12'h1c0));
      put(jump_op(21'h1f_fffc));
      bg_addr = 32'h1c0;
      bg_data = a;
      bg_on   = 1'b1;
      // handler at the trap vector
      wr_ptr = 128;
      put(addi_op(5'd2, 5'd0, 12'h05a));
      put(sw_abs(5'd2, 12'h1c4));
      expect_store(32'h1c4, 32'h5a);
    end
    default: begin
      put(addi_op(5'd0, 5'd0, 12'h055));
      put(sw_abs(5'd0, 12'h1d0));
      put(addi_op(5'd0, 5'd0, 12'h066));
      put(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd3));
      put(sw_abs(5'd3, 12'h1d4));
      expect_store(32'h1d0, 32'h0);
      expect_store(32'h1d4, 32'h0);
    end
  endcase
  put(jump_op(21'd0));
endtask

`endif

// ==== sim/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;

  logic        clk;
  logic        reset;
  logic        irq;
  logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  logic        dmem_we;
  logic [31:0] imem [1024];
  logic [31:0] dmem [256];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] lfsr = 32'he1d6;
  logic [31:0] bg_addr, bg_data;
  logic        bg_on;
  int          wr_ptr;
  int          errors;
  int          cycles;

  core_top #(.reset_vector(32'h0), .trap_vector(32'h200)) u_dut (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
    .dmem_we(dmem_we), .irq(irq)
  );

  assign imem_rdata = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  `include "tb_programs.svh"

  // store port is stable at the falling edge
  always @(negedge clk) begin
    if (!reset && dmem_we) begin
      if (bg_on && dmem_addr == bg_addr) begin
        assert (dmem_wdata == bg_data) else begin
          errors++;
          $display("** Error at %0t: dmem_wdata expected %h actual %h", $time, bg_data,
                   dmem_wdata);
        end
      end else if (exp_addr.size() == 0) begin
        errors++;
        $display("unexpected store of %h to %h at %0t", dmem_wdata, dmem_addr, $time);
      end else begin
        assert (dmem_addr == exp_addr[0]) else begin
          errors++;
          $display("** Error at %0t: dmem_addr expected %h actual %h", $time, exp_addr[0],
                   dmem_addr);
        end
        assert (dmem_wdata == exp_data[0]) else begin
          errors++;
          $display("** Error at %0t: dmem_wdata expected %h actual %h", $time, exp_data[0],
                   dmem_wdata);
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  initial begin
    reset  = 1'b1;
    irq    = 1'b0;
    bg_on  = 1'b0;
    errors = 0;
    for (int p = 0; p < 6; p++) begin
      @(negedge clk);
      reset = 1'b1;
      bg_on = 1'b0;
      exp_addr.delete();
      exp_data.delete();
      for (int i = 0; i < 1024; i++) begin
        imem[i] = jump_op(21'd0);
      end
      for (int i = 0; i < 256; i++) begin
        dmem[i] = i * 32'h9e37_79b9 + 32'h1357;
      end
      build_program(p);
      repeat (2) @(negedge clk);
      reset = 1'b0;
      if (p == 4) begin
        cycles = 0;
        while (!(dmem_we && dmem_addr == bg_addr) && cycles < 200) begin
          @(negedge clk);
          cycles++;
        end
        if (cycles >= 200) begin
          errors++;
          $display("store loop never started before the interrupt");
        end
        repeat (3) @(negedge clk);
        irq = 1'b1;
        @(negedge clk);
        irq = 1'b0;
        assert (imem_addr == 32'h200) else begin
          errors++;
          $display("** Error at %0t: imem_addr expected %h actual %h", $time, 32'h200,
                   imem_addr);
        end
      end
      cycles = 0;
      while (exp_addr.size() != 0 && cycles < 400) begin
        @(negedge clk);
        cycles++;
      end
      if (exp_addr.size() != 0) begin
        errors++;
        $display("program %0d timed out with %0d stores missing", p, exp_addr.size());
      end
      // catch a stray store behind the last expected one
      repeat (10) @(negedge clk);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+sim
rtl/core_pkg.sv
rtl/regfile.sv
rtl/mul_unit.sv
rtl/fetch_stage.sv
rtl/exec_stage.sv
rtl/mem_stage.sv
rtl/hazard_unit.sv
rtl/core_top.sv
sim/tb_core.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_core
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
